//--- atc.f
atc_pkg.sv
atc_fifo.sv
runway_manager.sv
reply_sender.sv
atc_controller.sv
atc_top.sv
atc_tb.sv

//--- atc_controller.sv
//////////////////////////////////////////////////////////////////////
// Tower controller FSM
// Interprets requests, holds the emergency latch, alternates service
// between the takeoff and landing queues and builds the reply message
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module atc_controller (
  input  logic                  clock,
  input  logic                  reset_n,
  input  atc_pkg::atc_msg_t     request,
  input  logic                  request_empty,
  output logic                  request_read,
  input  atc_pkg::plane_id_t    takeoff_id,
  input  atc_pkg::plane_id_t    landing_id,
  input  logic                  takeoff_full,
  input  logic                  takeoff_empty,
  input  logic                  landing_full,
  input  logic                  landing_empty,
  output logic                  takeoff_push,
  output logic                  landing_push,
  output logic                  takeoff_pop,
  output logic                  landing_pop,
  input  logic [1:0]            runway_active,
  output atc_pkg::runway_cmd_t  runway_cmd,
  input  logic                  reply_full,
  output atc_pkg::atc_msg_t     reply_msg,
  output logic                  reply_push
);

  import atc_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        emergency;
  logic        emergency_set;
  logic        emergency_clr;
  logic        takeoff_first;
  logic        reply_load;
  atc_msg_t    reply_next;
  logic        is_landing;
  logic        any_free;
  logic        free_runway;
  plane_id_t   cleared_id;

  assign is_landing = request.action[1];
  assign any_free   = !(&runway_active);

  // Lowest free runway, runway 1 only when runway 0 is taken
  assign free_runway = runway_active[0];

  // The plane popped in CHECK_QUEUES shows up on the FIFO output here
  assign cleared_id = (state == CLR_LANDING) ? landing_id : takeoff_id;

  //////////////////////////////////////////////////////////////////////
  // Next state and strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next    = state;
    request_read  = 1'b0;
    takeoff_push  = 1'b0;
    landing_push  = 1'b0;
    takeoff_pop   = 1'b0;
    landing_pop   = 1'b0;
    runway_cmd    = '{op: RW_NONE, runway: 1'b0, plane_id: '0};
    reply_push    = 1'b0;
    reply_load    = 1'b0;
    reply_next    = '{plane_id: request.plane_id, msg_type: T_HOLD, action: 2'b00};
    emergency_set = 1'b0;
    emergency_clr = 1'b0;

    case (state)
      QUIET: begin
        if (!request_empty) begin
          request_read = 1'b1;
          state_next   = INTERPRET;
        end else begin
          state_next = CHECK_QUEUES;
        end
      end

      INTERPRET: begin
        state_next = CHECK_QUEUES;
        case (request.msg_type)
          T_REQUEST: begin
            // Queued planes hear HOLD, rejected ones DIVERT
            state_next = REPLY;
            reply_load = 1'b1;
            if (is_landing) begin
              if (landing_full || emergency) begin
                reply_next.msg_type = T_DIVERT;
              end else begin
                landing_push = 1'b1;
              end
            end else begin
              if (takeoff_full) begin
                reply_next.msg_type = T_DIVERT;
              end else begin
                takeoff_push = 1'b1;
              end
            end
          end

          T_DECLARE: begin
            runway_cmd = '{op:       RW_UNLOCK,
                           runway:   request.action[0],
                           plane_id: request.plane_id};
          end

          T_EMERGENCY: begin
            if (request.action == 2'b01) begin
              emergency_set = 1'b1;
              // Start diverting right away if landings are waiting
              if (!landing_empty) begin
                landing_pop = 1'b1;
                state_next  = DIVERT_LANDING;
              end
            end else if (request.action == 2'b00) begin
              emergency_clr = 1'b1;
            end
          end

          default: begin
            state_next          = REPLY;
            reply_load          = 1'b1;
            reply_next.msg_type = T_SAY_AGAIN;
          end
        endcase
      end

      REPLY: begin
        if (!reply_full) begin
          reply_push = 1'b1;
          state_next = CHECK_QUEUES;
        end
      end

      CHECK_QUEUES: begin
        state_next = QUIET;
        if (emergency) begin
          if (!landing_empty) begin
            landing_pop = 1'b1;
            state_next  = DIVERT_LANDING;
          end
        end else if (any_free && !takeoff_empty && (landing_empty || takeoff_first)) begin
          takeoff_pop = 1'b1;
          state_next  = CLR_TAKEOFF;
        end else if (any_free && !landing_empty) begin
          landing_pop = 1'b1;
          state_next  = CLR_LANDING;
        end
      end

      CLR_TAKEOFF, CLR_LANDING: begin
        runway_cmd = '{op: RW_LOCK, runway: free_runway, plane_id: cleared_id};
        reply_load = 1'b1;
        reply_next = '{plane_id: cleared_id, msg_type: T_CLEAR, action: {1'b0, free_runway}};
        state_next = QUEUE_CLR;
      end

      DIVERT_LANDING: begin
        reply_load = 1'b1;
        reply_next = '{plane_id: landing_id, msg_type: T_DIVERT, action: 2'b00};
        state_next = QUEUE_CLR;
      end

      QUEUE_CLR: begin
        if (!reply_full) begin
          reply_push = 1'b1;
          state_next = QUIET;
        end
      end

      default: begin
        state_next = QUIET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State, emergency latch and service alternation
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state         <= QUIET;
      emergency     <= 1'b0;
      takeoff_first <= 1'b0;
    end else begin
      state         <= state_next;
      takeoff_first <= !takeoff_first;
      if (emergency_set) begin
        emergency <= 1'b1;
      end else if (emergency_clr) begin
        emergency <= 1'b0;
      end
    end
  end

  // Reply register, held while the reply FIFO pushes back
  always_ff @(posedge clock) begin
    if (reply_load) begin
      reply_msg <= reply_next;
    end
  end

endmodule

//--- atc_fifo.sv
//////////////////////////////////////////////////////////////////////
// Circular-buffer FIFO with put and get pointers and an item count
// The read port is registered into data_out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module atc_fifo #(
  parameter int width = 9,
  parameter int depth = 4
) (
  input  logic             clock,
  input  logic             reset_n,
  input  logic [width-1:0] data_in,
  input  logic             push,
  input  logic             pop,
  output logic [width-1:0] data_out,
  output logic             full,
  output logic             empty
);

  localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_w = $clog2(depth + 1);

  logic [width-1:0]   mem [depth];
  logic [ptr_w-1:0]   put_ptr;
  logic [ptr_w-1:0]   get_ptr;
  logic [count_w-1:0] count;
  logic               do_read;
  logic               do_write;

  // Wraps at depth so non power of two depths work too
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == count_w'(depth));

  // A read in the same cycle frees the slot for a write into a full buffer
  assign do_read  = pop && !empty;
  assign do_write = push && (!full || do_read);

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      put_ptr <= '0;
      get_ptr <= '0;
      count   <= '0;
    end else begin
      if (do_write) begin
        put_ptr <= ptr_inc(put_ptr);
      end
      if (do_read) begin
        get_ptr <= ptr_inc(get_ptr);
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and output register
  always_ff @(posedge clock) begin
    if (do_write) begin
      mem[put_ptr] <= data_in;
    end
    if (do_read) begin
      data_out <= mem[get_ptr];
    end
  end

endmodule

//--- atc_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types for the tower controller
// Message layout, message types and runway commands
// FSM state encodings for the controller and the reply sender
//////////////////////////////////////////////////////////////////////

package atc_pkg;

  localparam int plane_id_w = 4;

  typedef logic [plane_id_w-1:0] plane_id_t;

  // Inbound types sit below 3, replies use the upper half
  typedef enum logic [2:0] {
    T_REQUEST   = 3'd0,
    T_DECLARE   = 3'd1,
    T_EMERGENCY = 3'd2,
    T_CLEAR     = 3'd4,
    T_HOLD      = 3'd5,
    T_SAY_AGAIN = 3'd6,
    T_DIVERT    = 3'd7
  } msg_type_t;

  typedef struct packed {
    plane_id_t  plane_id;
    msg_type_t  msg_type;
    logic [1:0] action;
  } atc_msg_t;

  localparam int msg_w = $bits(atc_msg_t);

  typedef enum logic [1:0] {
    RW_NONE,
    RW_LOCK,
    RW_UNLOCK
  } runway_op_t;

  typedef struct packed {
    runway_op_t op;
    logic       runway;
    plane_id_t  plane_id;
  } runway_cmd_t;

  typedef enum logic [2:0] {
    QUIET,
    INTERPRET,
    REPLY,
    CHECK_QUEUES,
    CLR_TAKEOFF,
    CLR_LANDING,
    DIVERT_LANDING,
    QUEUE_CLR
  } ctrl_state_t;

  typedef enum logic {
    WAIT,
    SEND
  } send_state_t;

endpackage

//--- atc_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the tower controller top level
// Clock, reset, message stimulus, xorshift ids and tx_ready gaps,
// reference model of replies and runways, assertions and watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module atc_tb;

  import atc_pkg::*;

  localparam int queue_depth     = 4;
  localparam int scenario_count  = 6;
  localparam int watchdog_cycles = 8 + 400 * scenario_count;

  logic        clock = 1'b0;
  logic        reset_n;
  atc_msg_t    rx_msg;
  logic        rx_valid;
  logic        busy;
  atc_msg_t    tx_msg;
  logic        tx_ready;
  logic        tx_send;
  logic [1:0]  runway_active;

  int          error_count = 0;
  logic [31:0] id_state = 32'd6;
  logic [31:0] ready_state = 32'd6;
  logic        ready_random;
  atc_msg_t    expected [$];
  atc_msg_t    exp_msg;

  // Reference model state
  plane_id_t   take_q [$];
  plane_id_t   land_q [$];
  logic [1:0]  rw_busy = 2'b00;
  plane_id_t   rw_owner [2];
  logic        emerg_model = 1'b0;

  atc_top #(
    .queue_depth (queue_depth)
  ) u_dut (
    .clock         (clock),
    .reset_n       (reset_n),
    .rx_msg        (rx_msg),
    .rx_valid      (rx_valid),
    .busy          (busy),
    .tx_msg        (tx_msg),
    .tx_ready      (tx_ready),
    .tx_send       (tx_send),
    .runway_active (runway_active)
  );

  always #50 clock = ~clock;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function plane_id_t pick_id();
    id_state = xorshift(id_state);
    return id_state[3:0];
  endfunction

  function plane_id_t pick_other(input plane_id_t avoid);
    plane_id_t id;
    id = pick_id();
    if (id == avoid) begin
      id = id + 1'b1;
    end
    return id;
  endfunction

  function automatic atc_msg_t make_msg(input plane_id_t id, input logic [2:0] kind,
                                        input logic [1:0] action);
    atc_msg_t m;
    m.plane_id = id;
    m.msg_type = msg_type_t'(kind);
    m.action   = action;
    return m;
  endfunction

  task automatic step_cycle();
    @(posedge clock);
    #10;
  endtask

  task automatic expect_reply(input plane_id_t id, input msg_type_t kind,
                              input logic [1:0] action);
    expected.push_back(make_msg(id, kind, action));
  endtask

  // Diverts waiting landings in an emergency and otherwise fills free runways lowest first
  task automatic service_queues();
    plane_id_t id;
    logic      rw;
    logic      found;
    int        k;
    if (emerg_model) begin
      while (land_q.size() > 0) begin
        id = land_q.pop_front();
        expect_reply(id, T_DIVERT, 2'b00);
      end
    end else begin
      while (rw_busy != 2'b11 && (take_q.size() > 0 || land_q.size() > 0)) begin
        if (take_q.size() > 0) begin
          id = take_q.pop_front();
        end else begin
          id = land_q.pop_front();
        end
        // Search upward from runway 0 for the first one not held
        rw    = 1'b0;
        found = 1'b0;
        for (k = 0; k < 2; k++) begin
          if (!found && !rw_busy[k]) begin
            rw    = k[0];
            found = 1'b1;
          end
        end
        rw_busy[rw]  = 1'b1;
        rw_owner[rw] = id;
        expect_reply(id, T_CLEAR, {1'b0, rw});
      end
    end
  endtask

  task automatic model_msg(input atc_msg_t m);
    logic rw;
    rw = m.action[0];
    case (m.msg_type)
      T_REQUEST: begin
        if (m.action[1] && (land_q.size() == queue_depth || emerg_model)) begin
          expect_reply(m.plane_id, T_DIVERT, 2'b00);
        end else if (m.action[1]) begin
          land_q.push_back(m.plane_id);
          expect_reply(m.plane_id, T_HOLD, 2'b00);
        end else if (take_q.size() == queue_depth) begin
          expect_reply(m.plane_id, T_DIVERT, 2'b00);
        end else begin
          take_q.push_back(m.plane_id);
          expect_reply(m.plane_id, T_HOLD, 2'b00);
        end
      end
      T_DECLARE: begin
        if (rw_busy[rw] && rw_owner[rw] == m.plane_id) begin
          rw_busy[rw] = 1'b0;
        end
      end
      T_EMERGENCY: begin
        if (m.action == 2'b01) begin
          emerg_model = 1'b1;
        end else if (m.action == 2'b00) begin
          emerg_model = 1'b0;
        end
      end
      default: begin
        expect_reply(m.plane_id, T_SAY_AGAIN, 2'b00);
      end
    endcase
    service_queues();
  endtask

  // One strobe while the request FIFO has room and then idle spacing
  task automatic send_msg(input atc_msg_t m);
    while (busy) begin
      step_cycle();
    end
    rx_msg   = m;
    rx_valid = 1'b1;
    model_msg(m);
    step_cycle();
    rx_valid = 1'b0;
    repeat (2) step_cycle();
  endtask

  task automatic wait_replies();
    while (expected.size() != 0) begin
      step_cycle();
    end
    repeat (16) step_cycle();
    assert (runway_active == rw_busy) else begin
      error_count++;
      $display("Mismatch runway_active: got %h expected %h", runway_active, rw_busy);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clock) !reset_n |-> (!tx_send && !busy && runway_active == 2'b00))
  else begin
    error_count++;
    $display("Outputs not cleared during reset");
  end

  assert property (@(posedge clock) disable iff (!reset_n) tx_send |-> !$past(tx_send))
  else begin
    error_count++;
    $display("tx_send held high for more than one cycle");
  end

  assert property (@(posedge clock) disable iff (!reset_n) tx_send |-> $past(tx_ready))
  else begin
    error_count++;
    $display("tx_send pulsed although tx_ready was low");
  end

  // Replies are compared in order at the falling edge in mid pulse
  always @(negedge clock) begin
    if (reset_n && tx_send) begin
      if (expected.size() == 0) begin
        error_count++;
        $display("Unexpected reply %h with no reply pending", tx_msg);
      end else begin
        exp_msg = expected.pop_front();
        assert (tx_msg == exp_msg) else begin
          error_count++;
          $display("Mismatch tx_msg: got %h expected %h", tx_msg, exp_msg);
        end
      end
    end
  end

  // Random gaps on tx_ready
  always @(posedge clock) begin
    #10;
    if (ready_random && reset_n) begin
      ready_state = xorshift(ready_state);
      tx_ready    = (ready_state[1:0] != 2'b00);
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Timeout after %0d cycles with %0d replies pending",
             watchdog_cycles, expected.size());
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Scenarios
  //////////////////////////////////////////////////////////////////////

  initial begin
    plane_id_t a;
    plane_id_t b;
    int        i;
    reset_n      = 1'b1;
    rx_msg       = '0;
    rx_valid     = 1'b0;
    tx_ready     = 1'b1;
    ready_random = 1'b1;
    #1;
    reset_n = 1'b0;
    repeat (8) @(posedge clock);
    #10;
    reset_n = 1'b1;
    step_cycle();

    // Two takeoffs fill runway 0 then runway 1
    a = pick_id();
    send_msg(make_msg(a, T_REQUEST, 2'b00));
    wait_replies();
    b = pick_id();
    send_msg(make_msg(b, T_REQUEST, 2'b00));
    wait_replies();

    // Third takeoff waits until the owner of runway 0 declares
    send_msg(make_msg(pick_id(), T_REQUEST, 2'b00));
    wait_replies();
    send_msg(make_msg(pick_other(a), T_DECLARE, 2'b00));
    wait_replies();
    send_msg(make_msg(a, T_DECLARE, 2'b00));
    wait_replies();

    // Invalid message type
    send_msg(make_msg(pick_id(), 3'd3, 2'b00));
    wait_replies();

    // Emergency diverts the waiting landings and new ones
    for (i = 0; i < 2; i++) begin
      send_msg(make_msg(pick_id(), T_REQUEST, 2'b10));
      wait_replies();
    end
    send_msg(make_msg(pick_id(), T_EMERGENCY, 2'b01));
    wait_replies();
    send_msg(make_msg(pick_id(), T_REQUEST, 2'b10));
    wait_replies();
    send_msg(make_msg(pick_id(), T_EMERGENCY, 2'b00));
    wait_replies();
    send_msg(make_msg(pick_id(), T_REQUEST, 2'b10));
    wait_replies();
    send_msg(make_msg(b, T_DECLARE, 2'b01));
    wait_replies();

    // Five takeoffs against a queue of four
    for (i = 0; i < 5; i++) begin
      send_msg(make_msg(pick_id(), T_REQUEST, 2'b00));
      wait_replies();
    end

    // Replies blocked until the request FIFO fills
    ready_random = 1'b0;
    step_cycle();
    tx_ready = 1'b0;
    i = 0;
    while (!busy && i < 14) begin
      send_msg(make_msg(pick_id(), 3'd3, 2'b00));
      i++;
    end
    assert (busy) else begin
      error_count++;
      $display("busy stayed low while replies were blocked");
    end
    // This one finds the request FIFO full and is dropped
    rx_msg   = make_msg(pick_id(), T_REQUEST, 2'b00);
    rx_valid = 1'b1;
    step_cycle();
    rx_valid = 1'b0;
    repeat (20) step_cycle();
    tx_ready = 1'b1;
    wait_replies();

    $display("Run complete with %0d errors", error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- atc_top.sv
//////////////////////////////////////////////////////////////////////
// Tower controller top level
// Request FIFO, takeoff and landing queues, controller,
// runway manager and reply sender
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module atc_top #(
  parameter int queue_depth = 4
) (
  input  logic              clock,
  input  logic              reset_n,
  input  atc_pkg::atc_msg_t rx_msg,
  input  logic              rx_valid,
  output logic              busy,
  output atc_pkg::atc_msg_t tx_msg,
  input  logic              tx_ready,
  output logic              tx_send,
  output logic [1:0]        runway_active
);

  import atc_pkg::*;

  atc_msg_t    request;
  logic        request_empty;
  logic        request_read;
  plane_id_t   takeoff_id;
  plane_id_t   landing_id;
  logic        takeoff_full;
  logic        takeoff_empty;
  logic        landing_full;
  logic        landing_empty;
  logic        takeoff_push;
  logic        landing_push;
  logic        takeoff_pop;
  logic        landing_pop;
  runway_cmd_t runway_cmd;
  atc_msg_t    reply_msg;
  logic        reply_push;
  logic        reply_full;

  // Incoming messages, busy while full
  atc_fifo #(
    .width (msg_w),
    .depth (queue_depth)
  ) u_request_fifo (
    .clock    (clock),
    .reset_n  (reset_n),
    .data_in  (rx_msg),
    .push     (rx_valid),
    .pop      (request_read),
    .data_out (request),
    .full     (busy),
    .empty    (request_empty)
  );

  // Both aircraft queues take the id of the request being interpreted
  atc_fifo #(
    .width (plane_id_w),
    .depth (queue_depth)
  ) u_takeoff_fifo (
    .clock    (clock),
    .reset_n  (reset_n),
    .data_in  (request.plane_id),
    .push     (takeoff_push),
    .pop      (takeoff_pop),
    .data_out (takeoff_id),
    .full     (takeoff_full),
    .empty    (takeoff_empty)
  );

  atc_fifo #(
    .width (plane_id_w),
    .depth (queue_depth)
  ) u_landing_fifo (
    .clock    (clock),
    .reset_n  (reset_n),
    .data_in  (request.plane_id),
    .push     (landing_push),
    .pop      (landing_pop),
    .data_out (landing_id),
    .full     (landing_full),
    .empty    (landing_empty)
  );

  atc_controller u_controller (
    .clock         (clock),
    .reset_n       (reset_n),
    .request       (request),
    .request_empty (request_empty),
    .request_read  (request_read),
    .takeoff_id    (takeoff_id),
    .landing_id    (landing_id),
    .takeoff_full  (takeoff_full),
    .takeoff_empty (takeoff_empty),
    .landing_full  (landing_full),
    .landing_empty (landing_empty),
    .takeoff_push  (takeoff_push),
    .landing_push  (landing_push),
    .takeoff_pop   (takeoff_pop),
    .landing_pop   (landing_pop),
    .runway_active (runway_active),
    .runway_cmd    (runway_cmd),
    .reply_full    (reply_full),
    .reply_msg     (reply_msg),
    .reply_push    (reply_push)
  );

  runway_manager u_runway_manager (
    .clock         (clock),
    .reset_n       (reset_n),
    .runway_cmd    (runway_cmd),
    .runway_active (runway_active)
  );

  reply_sender #(
    .depth (queue_depth)
  ) u_reply_sender (
    .clock      (clock),
    .reset_n    (reset_n),
    .reply_msg  (reply_msg),
    .reply_push (reply_push),
    .reply_full (reply_full),
    .tx_ready   (tx_ready),
    .tx_msg     (tx_msg),
    .tx_send    (tx_send)
  );

endmodule

//--- reply_sender.sv
//////////////////////////////////////////////////////////////////////
// Reply sender
// Reply FIFO and the WAIT/SEND sequencer that drives the send strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reply_sender #(
  parameter int depth = 4
) (
  input  logic              clock,
  input  logic              reset_n,
  input  atc_pkg::atc_msg_t reply_msg,
  input  logic              reply_push,
  output logic              reply_full,
  input  logic              tx_ready,
  output atc_pkg::atc_msg_t tx_msg,
  output logic              tx_send
);

  import atc_pkg::*;

  send_state_t state;
  send_state_t state_next;
  logic        fifo_pop;
  logic        fifo_empty;

  atc_fifo #(
    .width (msg_w),
    .depth (depth)
  ) u_reply_fifo (
    .clock    (clock),
    .reset_n  (reset_n),
    .data_in  (reply_msg),
    .push     (reply_push),
    .pop      (fifo_pop),
    .data_out (tx_msg),
    .full     (reply_full),
    .empty    (fifo_empty)
  );

  // The FIFO output is valid one cycle after the pop, so SEND follows WAIT
  always_comb begin
    state_next = state;
    fifo_pop   = 1'b0;
    tx_send    = 1'b0;
    case (state)
      WAIT: begin
        if (!fifo_empty && tx_ready) begin
          fifo_pop   = 1'b1;
          state_next = SEND;
        end
      end
      SEND: begin
        tx_send    = 1'b1;
        state_next = WAIT;
      end
      default: begin
        state_next = WAIT;
      end
    endcase
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state <= WAIT;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the tower controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -Wno-fatal --top-module atc_tb \
  -f atc.f -o atc_sim || exit 1
out=$(./obj_dir/atc_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1

//--- runway_manager.sv
//////////////////////////////////////////////////////////////////////
// Runway manager
// Lock state and owning plane id of each of the two runways
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module runway_manager (
  input  logic                 clock,
  input  logic                 reset_n,
  input  atc_pkg::runway_cmd_t runway_cmd,
  output logic [1:0]           runway_active
);

  import atc_pkg::*;

  plane_id_t owner [2];
  logic      owner_match;

  // Only the plane holding a runway may release it
  assign owner_match = (owner[runway_cmd.runway] == runway_cmd.plane_id);

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      runway_active <= 2'b00;
    end else begin
      case (runway_cmd.op)
        RW_LOCK: begin
          runway_active[runway_cmd.runway] <= 1'b1;
        end
        RW_UNLOCK: begin
          if (owner_match) begin
            runway_active[runway_cmd.runway] <= 1'b0;
          end
        end
        default: begin
          runway_active <= runway_active;
        end
      endcase
    end
  end

  // Owner ids
  always_ff @(posedge clock) begin
    if (runway_cmd.op == RW_LOCK) begin
      owner[runway_cmd.runway] <= runway_cmd.plane_id;
    end
  end

endmodule
